// File: logic/stack_pkg.sv
`default_nettype none

package stack_pkg;

    // ====================
    // Opcodes
    // ====================

    typedef enum logic
    {
        ALU_ADD = 1'b0, // op1 + op2.
        ALU_SUB = 1'b1  // op1 - op2.
    } alu_op_e;

    typedef enum logic
    {
        HOST_PUSH = 1'b0,
        HOST_POP  = 1'b1
    } host_op_e;

    // ====================
    // ALU sequencer
    // ====================

    typedef enum logic [3:0]
    {
        ALU_IDLE = 4'd0,
        ALU_REQ  = 4'd1, // Waiting for the stack grant.
        OP1_POP  = 4'd2,
        OP1_RCV  = 4'd3,
        OP2_POP  = 4'd4,
        OP2_RCV  = 4'd5,
        ALU_EXEC = 4'd6,
        ALU_PUSH = 4'd7  // Result push and finish pulse.
    } alu_state_e;

endpackage

`default_nettype wire

// File: logic/stack_mem.sv
`timescale 1ns/1ns
`default_nettype none

module stack_mem #(
    parameter int DATA_LEN    = 8,
    parameter int STACK_DEPTH = 16
) (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 push,
    input  wire                 pop,
    input  wire  [DATA_LEN-1:0] wr_data,
    output logic [DATA_LEN-1:0] rd_data,
    output logic                empty,
    output logic                full,
    output logic                err
);

    localparam int PTR_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
    localparam int CNT_W = $clog2(STACK_DEPTH + 1);

    logic [DATA_LEN-1:0] mem [STACK_DEPTH]; // Entry 0 is the bottom.
    logic [CNT_W-1:0]    sp;                // Number of entries, next free slot.
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    top_ptr;
    logic                do_push;
    logic                do_pop;

    assign empty   = (sp == '0);
    assign full    = (sp == CNT_W'(STACK_DEPTH));
    assign wr_ptr  = sp[PTR_W-1:0];
    assign top_ptr = PTR_W'(sp - 1'b1);

    // A push wins if both strobes ever arrive together.
    assign do_push = push && !full;
    assign do_pop  = pop && !push && !empty;

    // ====================
    // Pointer and error
    // ====================

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            sp  <= '0;
            err <= 1'b0;
        end
        else
        begin
            if (do_push)
                sp <= sp + 1'b1;
            else if (do_pop)
                sp <= sp - 1'b1;

            if ((push && full) || (pop && !push && empty))
                err <= 1'b1; // Sticky until reset.
        end
    end

    // ====================
    // Storage
    // ====================

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= wr_data;

        if (do_pop)
            rd_data <= mem[top_ptr]; // Valid the cycle after the strobe.
        else if (pop && !push)
            rd_data <= '0; // Underflow reads back zero.
    end

endmodule

`default_nettype wire

// File: logic/stack_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module stack_arbiter #(
    parameter int DATA_LEN = 8
) (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 alu_req,
    input  wire                 alu_push,
    input  wire                 alu_pop,
    input  wire  [DATA_LEN-1:0] alu_wr_data,
    input  wire                 host_req,
    input  wire                 host_push,
    input  wire                 host_pop,
    input  wire  [DATA_LEN-1:0] host_wr_data,
    output logic                alu_gnt,
    output logic                host_gnt,
    output logic                push,
    output logic                pop,
    output logic [DATA_LEN-1:0] wr_data
);

    logic last_host; // Last served peer, 0 means the ALU.

    // ====================
    // Grant
    // ====================

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            alu_gnt   <= 1'b0;
            host_gnt  <= 1'b0;
            last_host <= 1'b0; // Host wins the first tie.
        end
        else if (alu_gnt)
        begin
            if (!alu_req)
                alu_gnt <= 1'b0; // Locked until the owner lets go.
        end
        else if (host_gnt)
        begin
            if (!host_req)
                host_gnt <= 1'b0;
        end
        else if (alu_req && (!host_req || last_host))
        begin
            alu_gnt   <= 1'b1;
            last_host <= 1'b0;
        end
        else if (host_req)
        begin
            host_gnt  <= 1'b1;
            last_host <= 1'b1;
        end
    end

    // ====================
    // Routing
    // ====================

    // Only the owner reaches the stack.
    assign push = (alu_gnt && alu_push) || (host_gnt && host_push);
    assign pop  = (alu_gnt && alu_pop) || (host_gnt && host_pop);

    always_comb
    begin
        if (alu_gnt)
            wr_data = alu_wr_data;
        else if (host_gnt)
            wr_data = host_wr_data;
        else
            wr_data = '0;
    end

endmodule

`default_nettype wire

// File: logic/stack_alu.sv
`timescale 1ns/1ns
`default_nettype none

module stack_alu #(
    parameter int DATA_LEN = 8
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          start,
    input  wire stack_pkg::alu_op_e      op,
    input  wire                          gnt,
    input  wire  [DATA_LEN-1:0]          rd_data,
    output logic                         req,
    output logic                         push,
    output logic                         pop,
    output logic [DATA_LEN-1:0]          wr_data,
    output logic                         busy,
    output logic                         fin_sig,
    output logic                         z_flag,
    output logic                         s_flag
);

    import stack_pkg::*;

    alu_state_e                 state;
    alu_op_e                    op_q;    // Opcode held for the whole job.
    logic signed [DATA_LEN-1:0] op1;     // First pop, top of the stack.
    logic signed [DATA_LEN-1:0] op2;
    logic signed [DATA_LEN-1:0] res;
    logic signed [DATA_LEN-1:0] alu_out;

    // Wraps at DATA_LEN bits.
    assign alu_out = (op_q == ALU_ADD) ? (op1 + op2) : (op1 - op2);

    // ====================
    // Sequencer
    // ====================

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state  <= ALU_IDLE;
            op_q   <= ALU_ADD;
            z_flag <= 1'b0;
            s_flag <= 1'b0;
        end
        else
        begin
            case (state)
                ALU_IDLE:
                begin
                    if (start)
                    begin
                        op_q  <= op;
                        state <= ALU_REQ;
                    end
                end
                ALU_REQ:
                begin
                    if (gnt)
                        state <= OP1_POP;
                end
                OP1_POP:  state <= OP1_RCV;
                OP1_RCV:  state <= OP2_POP;
                OP2_POP:  state <= OP2_RCV;
                OP2_RCV:  state <= ALU_EXEC;
                ALU_EXEC:
                begin
                    // Flags change on the same edge that raises fin_sig.
                    z_flag <= (alu_out == '0);
                    s_flag <= alu_out[DATA_LEN-1];
                    state  <= ALU_PUSH;
                end
                ALU_PUSH: state <= ALU_IDLE;
                default:  state <= ALU_IDLE;
            endcase
        end
    end

    // ====================
    // Datapath
    // ====================

    always_ff @(posedge clk)
    begin
        if (state == OP1_RCV)
            op1 <= signed'(rd_data); // Stack data lands one cycle after pop.
        if (state == OP2_RCV)
            op2 <= signed'(rd_data);
        if (state == ALU_EXEC)
            res <= alu_out;
    end

    // Strobes are decoded from the state.
    assign busy    = (state != ALU_IDLE);
    assign req     = busy;                  // Held until the push is done.
    assign pop     = (state == OP1_POP) || (state == OP2_POP);
    assign push    = (state == ALU_PUSH);
    assign fin_sig = (state == ALU_PUSH);
    assign wr_data = push ? res : '0;       // Idle data is driven low.

endmodule

`default_nettype wire

// File: logic/host_port.sv
`timescale 1ns/1ns
`default_nettype none

module host_port #(
    parameter int DATA_LEN = 8
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          valid,
    input  wire stack_pkg::host_op_e     op,
    input  wire  [DATA_LEN-1:0]          data,
    input  wire                          gnt,
    input  wire  [DATA_LEN-1:0]          rd_data,
    output logic                         req,
    output logic                         push,
    output logic                         pop,
    output logic [DATA_LEN-1:0]          wr_data,
    output logic                         busy,
    output logic                         rd_valid,
    output logic [DATA_LEN-1:0]          rd_out
);

    import stack_pkg::*;

    typedef enum logic [2:0]
    {
        H_IDLE,
        H_REQ,
        H_PUSH,
        H_POP,
        H_RCV
    } host_state_e;

    host_state_e         state;
    host_op_e            op_q;
    logic [DATA_LEN-1:0] data_q; // Push value latched with the command.

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= H_IDLE;
            op_q  <= HOST_PUSH;
        end
        else
        begin
            case (state)
                H_IDLE:
                begin
                    if (valid)
                    begin
                        op_q  <= op;
                        state <= H_REQ;
                    end
                end
                H_REQ:
                begin
                    if (gnt)
                        state <= (op_q == HOST_PUSH) ? H_PUSH : H_POP;
                end
                H_POP:   state <= H_RCV;
                default: state <= H_IDLE; // Push and receive end the job.
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == H_IDLE) && valid)
            data_q <= data;
    end

    assign busy     = (state != H_IDLE);
    assign req      = busy;
    assign push     = (state == H_PUSH);
    assign pop      = (state == H_POP);
    assign wr_data  = push ? data_q : '0;
    assign rd_valid = (state == H_RCV);        // Stack data is valid this cycle.
    assign rd_out   = rd_valid ? rd_data : '0;

endmodule

`default_nettype wire

// File: logic/stack_machine.sv
`timescale 1ns/1ns
`default_nettype none

module stack_machine #(
    parameter int DATA_LEN    = 8,
    parameter int STACK_DEPTH = 16
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          alu_start,
    input  wire stack_pkg::alu_op_e      alu_op,
    input  wire                          host_valid,
    input  wire stack_pkg::host_op_e     host_op,
    input  wire  [DATA_LEN-1:0]          host_data,
    output logic                         alu_busy,
    output logic                         fin_sig,
    output logic                         z_flag,
    output logic                         s_flag,
    output logic                         host_busy,
    output logic                         rd_valid,
    output logic [DATA_LEN-1:0]          rd_data,
    output logic                         stack_empty,
    output logic                         stack_full,
    output logic                         stack_err
);

    // ====================
    // Peer to arbiter
    // ====================

    logic                alu_req;
    logic                alu_gnt;
    logic                alu_push;
    logic                alu_pop;
    logic [DATA_LEN-1:0] alu_wr_data;
    logic                host_req;
    logic                host_gnt;
    logic                host_push;
    logic                host_pop;
    logic [DATA_LEN-1:0] host_wr_data;

    // Arbiter to stack.
    logic                stk_push;
    logic                stk_pop;
    logic [DATA_LEN-1:0] stk_wr_data;
    logic [DATA_LEN-1:0] stk_rd_data; // Shared by both peers.

    stack_alu #(
        .DATA_LEN (DATA_LEN)
    ) stack_alu_inst (
        .clk     (clk),
        .rstn    (rstn),
        .start   (alu_start),
        .op      (alu_op),
        .gnt     (alu_gnt),
        .rd_data (stk_rd_data),
        .req     (alu_req),
        .push    (alu_push),
        .pop     (alu_pop),
        .wr_data (alu_wr_data),
        .busy    (alu_busy),
        .fin_sig (fin_sig),
        .z_flag  (z_flag),
        .s_flag  (s_flag)
    );

    host_port #(
        .DATA_LEN (DATA_LEN)
    ) host_port_inst (
        .clk      (clk),
        .rstn     (rstn),
        .valid    (host_valid),
        .op       (host_op),
        .data     (host_data),
        .gnt      (host_gnt),
        .rd_data  (stk_rd_data),
        .req      (host_req),
        .push     (host_push),
        .pop      (host_pop),
        .wr_data  (host_wr_data),
        .busy     (host_busy),
        .rd_valid (rd_valid),
        .rd_out   (rd_data)
    );

    stack_arbiter #(
        .DATA_LEN (DATA_LEN)
    ) stack_arbiter_inst (
        .clk          (clk),
        .rstn         (rstn),
        .alu_req      (alu_req),
        .alu_push     (alu_push),
        .alu_pop      (alu_pop),
        .alu_wr_data  (alu_wr_data),
        .host_req     (host_req),
        .host_push    (host_push),
        .host_pop     (host_pop),
        .host_wr_data (host_wr_data),
        .alu_gnt      (alu_gnt),
        .host_gnt     (host_gnt),
        .push         (stk_push),
        .pop          (stk_pop),
        .wr_data      (stk_wr_data)
    );

    stack_mem #(
        .DATA_LEN    (DATA_LEN),
        .STACK_DEPTH (STACK_DEPTH)
    ) stack_mem_inst (
        .clk     (clk),
        .rstn    (rstn),
        .push    (stk_push),
        .pop     (stk_pop),
        .wr_data (stk_wr_data),
        .rd_data (stk_rd_data),
        .empty   (stack_empty),
        .full    (stack_full),
        .err     (stack_err)
    );

endmodule

`default_nettype wire

// File: testbench/tb_stack_machine.sv
`timescale 1ns/1ns
`default_nettype none

module tb_stack_machine;

    import stack_pkg::*;

    localparam int DATA_LEN    = 8;
    localparam int STACK_DEPTH = 16;
    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TESTS   = 5;
    localparam int WAIT_LIMIT  = 200; // Cycles allowed for one job.

    logic                clk;
    logic                rstn;
    logic                alu_start;
    alu_op_e             alu_op;
    logic                host_valid;
    host_op_e            host_op;
    logic [DATA_LEN-1:0] host_data;
    logic                alu_busy;
    logic                fin_sig;
    logic                z_flag;
    logic                s_flag;
    logic                host_busy;
    logic                rd_valid;
    logic [DATA_LEN-1:0] rd_data;
    logic                stack_empty;
    logic                stack_full;
    logic                stack_err;

    logic [DATA_LEN-1:0] model_q[$];  // Back of the queue is the top.
    logic                model_err;
    logic                last_host;   // Last served peer, 0 means the ALU.
    logic [31:0]         lcg_state;
    int                  err_count;
    int                  errs_at_start;
    int                  tests_done;

    stack_machine #(
        .DATA_LEN    (DATA_LEN),
        .STACK_DEPTH (STACK_DEPTH)
    ) stack_machine_inst (
        .clk         (clk),
        .rstn        (rstn),
        .alu_start   (alu_start),
        .alu_op      (alu_op),
        .host_valid  (host_valid),
        .host_op     (host_op),
        .host_data   (host_data),
        .alu_busy    (alu_busy),
        .fin_sig     (fin_sig),
        .z_flag      (z_flag),
        .s_flag      (s_flag),
        .host_busy   (host_busy),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .stack_empty (stack_empty),
        .stack_full  (stack_full),
        .stack_err   (stack_err)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [DATA_LEN-1:0] rand_data();
        logic [31:0] r;
        r = lcg_next();
        return r[16 +: DATA_LEN]; // Upper bits are the better ones.
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = lcg_next();
        return r[20];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic tick();
        @(posedge clk);
        #2; // Drive and sample point.
    endtask

    task automatic apply_reset();
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rstn      = 1'b1;
        model_q.delete();
        model_err = 1'b0;
        last_host = 1'b0; // Host wins the first tie.
    endtask

    // ====================
    // Reference model
    // ====================

    task automatic model_push(input logic [DATA_LEN-1:0] v);
        if (model_q.size() == STACK_DEPTH)
            model_err = 1'b1; // Dropped.
        else
            model_q.push_back(v);
    endtask

    task automatic model_pop(output logic [DATA_LEN-1:0] v);
        if (model_q.size() == 0)
        begin
            v         = '0;
            model_err = 1'b1;
        end
        else
            v = model_q.pop_back();
    endtask

    task automatic model_alu(input alu_op_e op, output logic [DATA_LEN-1:0] res);
        logic [DATA_LEN-1:0] a;
        logic [DATA_LEN-1:0] b;
        model_pop(a); // Top of the stack.
        model_pop(b);
        if (op == ALU_ADD)
            res = a + b;
        else
            res = a - b;
        model_push(res);
    endtask

    task automatic model_host(input host_op_e op, input logic [DATA_LEN-1:0] v,
                              output logic [DATA_LEN-1:0] popped);
        popped = '0;
        if (op == HOST_PUSH)
            model_push(v);
        else
            model_pop(popped);
    endtask

    // ====================
    // Checks on status
    // ====================

    task automatic check_status();
        if (stack_err !== model_err)
            report_mismatch("stack_err", 32'(model_err), 32'(stack_err));
        if (stack_empty !== (model_q.size() == 0))
            report_mismatch("stack_empty", 32'(model_q.size() == 0), 32'(stack_empty));
        if (stack_full !== (model_q.size() == STACK_DEPTH))
            report_mismatch("stack_full", 32'(model_q.size() == STACK_DEPTH), 32'(stack_full));
    endtask

    task automatic check_reset_outputs();
        if (alu_busy !== 1'b0)
            report_mismatch("alu_busy", 32'd0, 32'(alu_busy));
        if (host_busy !== 1'b0)
            report_mismatch("host_busy", 32'd0, 32'(host_busy));
        if (fin_sig !== 1'b0)
            report_mismatch("fin_sig", 32'd0, 32'(fin_sig));
        if (rd_valid !== 1'b0)
            report_mismatch("rd_valid", 32'd0, 32'(rd_valid));
        if ((z_flag !== 1'b0) || (s_flag !== 1'b0))
            report_mismatch("z_flag/s_flag", 32'd0, 32'({z_flag, s_flag}));
        check_status();
    endtask

    task automatic check_flags(input logic [DATA_LEN-1:0] res, input logic z, input logic s);
        if (z !== (res == '0))
            report_mismatch("z_flag", 32'(res == '0), 32'(z));
        if (s !== res[DATA_LEN-1])
            report_mismatch("s_flag", 32'(res[DATA_LEN-1]), 32'(s));
    endtask

    task automatic end_test(input string name);
        check_status();
        tests_done++;
        $display("Test %0d %s finished with %0d errors", tests_done, name,
                 err_count - errs_at_start);
        errs_at_start = err_count;
    endtask

    // ====================
    // Jobs on the DUT
    // ====================

    task automatic wait_host_idle();
        int n;
        n = 0;
        while (host_busy && (n < WAIT_LIMIT))
        begin
            tick();
            n++;
        end
        if (host_busy)
        begin
            $display("Host job did not finish in time at t=%0t", $time);
            err_count++;
        end
    endtask

    task automatic host_push(input logic [DATA_LEN-1:0] v);
        host_valid = 1'b1;
        host_op    = HOST_PUSH;
        host_data  = v;
        tick();
        host_valid = 1'b0;
        wait_host_idle();
        model_push(v);
        last_host = 1'b1;
    endtask

    task automatic host_pop();
        logic [DATA_LEN-1:0] exp;
        int                  n;
        host_valid = 1'b1;
        host_op    = HOST_POP;
        tick();
        host_valid = 1'b0;
        n = 0;
        while (!rd_valid && (n < WAIT_LIMIT))
        begin
            tick();
            n++;
        end
        model_pop(exp);
        if (!rd_valid)
        begin
            $display("No rd_valid pulse for a host pop at t=%0t", $time);
            err_count++;
        end
        else if (rd_data !== exp)
            report_mismatch("rd_data", 32'(exp), 32'(rd_data));
        tick();
        wait_host_idle();
        last_host = 1'b1;
    endtask

    task automatic alu_run(input alu_op_e op, output int latency);
        logic [DATA_LEN-1:0] res;
        alu_start = 1'b1;
        alu_op    = op;
        tick();
        alu_start = 1'b0;
        latency   = 0; // Edges after the start edge.
        while (!fin_sig && (latency < WAIT_LIMIT))
        begin
            tick();
            latency++;
        end
        if (!fin_sig)
        begin
            $display("ALU job never raised fin_sig at t=%0t", $time);
            err_count++;
        end
        else
        begin
            model_alu(op, res);
            check_flags(res, z_flag, s_flag);
        end
        tick();
        if (alu_busy !== 1'b0)
            report_mismatch("alu_busy", 32'd0, 32'(alu_busy));
        last_host = 1'b0;
    endtask

    task automatic concurrent_round(input alu_op_e aop, input host_op_e hop,
                                    input logic [DATA_LEN-1:0] v);
        logic [DATA_LEN-1:0] res;
        logic [DATA_LEN-1:0] popped;
        logic [DATA_LEN-1:0] exp_pop;
        logic                got_pop;
        logic                got_fin;
        logic                fin_z;
        logic                fin_s;
        int                  n;
        alu_start  = 1'b1;
        alu_op     = aop;
        host_valid = 1'b1;
        host_op    = hop;
        host_data  = v;
        tick();
        alu_start  = 1'b0;
        host_valid = 1'b0;
        got_pop = 1'b0;
        got_fin = 1'b0;
        popped  = '0;
        fin_z   = 1'b0;
        fin_s   = 1'b0;
        n = 0;
        while ((alu_busy || host_busy) && (n < 2 * WAIT_LIMIT))
        begin
            if (rd_valid)
            begin
                got_pop = 1'b1;
                popped  = rd_data;
            end
            if (fin_sig)
            begin
                got_fin = 1'b1;
                fin_z   = z_flag;
                fin_s   = s_flag;
            end
            tick();
            n++;
        end
        // Tie goes to the peer not served last.
        if (last_host)
        begin
            model_alu(aop, res);
            model_host(hop, v, exp_pop);
        end
        else
        begin
            model_host(hop, v, exp_pop);
            model_alu(aop, res);
        end
        // The tie loser goes second, so the last served peer stays the same.
        if (alu_busy || host_busy)
        begin
            $display("Concurrent jobs did not finish in time at t=%0t", $time);
            err_count++;
        end
        if (!got_fin)
        begin
            $display("ALU job in a concurrent round gave no fin_sig at t=%0t", $time);
            err_count++;
        end
        else
            check_flags(res, fin_z, fin_s);
        if ((hop == HOST_POP) && !got_pop)
        begin
            $display("Host pop in a concurrent round gave no rd_valid at t=%0t", $time);
            err_count++;
        end
        else if ((hop == HOST_POP) && (popped !== exp_pop))
            report_mismatch("rd_data", 32'(exp_pop), 32'(popped));
    endtask

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        int                  lat;
        logic [DATA_LEN-1:0] v;
        alu_op_e             aop;
        host_op_e            hop;
        rstn          = 1'b0;
        alu_start     = 1'b0;
        alu_op        = ALU_ADD;
        host_valid    = 1'b0;
        host_op       = HOST_PUSH;
        host_data     = '0;
        lcg_state     = 32'h8dd4;
        err_count     = 0;
        errs_at_start = 0;
        tests_done    = 0;
        model_err     = 1'b0;
        last_host     = 1'b0;
        apply_reset();
        check_reset_outputs();

        // Push/pop order.
        repeat (10) host_push(rand_data());
        repeat (10) host_pop();
        end_test("push/pop order");

        // ALU arithmetic, with one pair that forces a zero result.
        host_push(8'h5a);
        host_push(8'h5a);
        alu_run(ALU_SUB, lat);
        host_pop();
        repeat (12)
        begin
            host_push(rand_data());
            host_push(rand_data());
            aop = rand_bit() ? ALU_SUB : ALU_ADD;
            alu_run(aop, lat);
            host_pop();
        end
        end_test("ALU arithmetic");

        // Fixed ALU latency with the host idle.
        repeat (3)
        begin
            host_push(rand_data());
            host_push(rand_data());
            alu_run(ALU_ADD, lat);
            if (lat != 7)
                report_mismatch("fin_sig latency", 32'd7, 32'(lat));
            host_pop();
        end
        end_test("ALU latency");

        // Concurrent peers, then read back what is left.
        repeat (6) host_push(rand_data());
        repeat (12)
        begin
            if ((model_q.size() >= 3) && rand_bit())
                alu_run(ALU_ADD, lat); // A solo ALU job hands the next tie to the host.
            aop = rand_bit() ? ALU_SUB : ALU_ADD;
            hop = HOST_PUSH; // Keeps enough operands below the ALU.
            if ((model_q.size() > 4) && rand_bit())
                hop = HOST_POP;
            v = rand_data();
            concurrent_round(aop, hop, v);
        end
        while (model_q.size() > 0)
            host_pop();
        end_test("concurrent peers");

        // Underflow, overflow and reset.
        host_pop();
        check_status();
        repeat (STACK_DEPTH + 1) host_push(rand_data());
        check_status();
        host_pop();
        apply_reset();
        check_reset_outputs();
        end_test("underflow/overflow");

        $display("Tests run %0d, errors %0d", tests_done, err_count);
        if (err_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Watchdog sized by the test count.
    initial
    begin
        #(NUM_TESTS * 5000 * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/stack_pkg.sv
logic/stack_mem.sv
logic/stack_arbiter.sv
logic/stack_alu.sv
logic/host_port.sv
logic/stack_machine.sv
testbench/tb_stack_machine.sv

// File: run.sh
#!/bin/sh
# Compile and run the stack machine testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_stack_machine \
    -f vlog.f \
    -o sim_stack_machine

./obj_dir/sim_stack_machine | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
